// File: all.f
verilog/rv_isa_pkg.sv
verilog/rv_pipe_pkg.sv
verilog/id_ex_if.sv
verilog/rv_regfile.sv
verilog/rv_decode.sv
verilog/rv_id_ex_reg.sv
verilog/rv_execute.sv
verilog/rv_backend_top.sv
verif/tb_rv_backend.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module tb_rv_backend -o tb_rv_backend

./obj_dir/tb_rv_backend > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: errors found" sim.log; then
    exit 1
fi
grep -q "Done: no errors" sim.log

// File: verif/tb_rv_backend.sv
`timescale 1ns/1ps

module tb_rv_backend;
    localparam int period_ns   = 8;
    localparam int rst_cycles  = 8;
    localparam int max_issues  = 300;          // Upper bound of issued cycles
    localparam int timeout_ns  = (rst_cycles + max_issues + 50) * period_ns;

    logic        i_clock;
    logic        i_rst_n;
    logic        i_inst_valid;
    logic [31:0] i_inst;
    logic [31:0] i_pc;
    logic        i_flush;
    logic        o_wb_valid;
    logic [4:0]  o_wb_addr;
    logic [31:0] o_wb_data;

    logic [31:0] regs [32];                    // Register mirror
    logic [7:0]  mem [256];                    // Byte memory mirror
    logic [15:0] lfsr_state = 16'd92;
    logic [31:0] next_pc = 32'h0000_1000;
    logic        pend_valid;                   // Expected o_wb_* of last issue
    logic [4:0]  pend_addr;
    logic [31:0] pend_data;
    string       pend_name;

    rv_backend_top i_dut (.*);

    initial begin
        i_clock = 1'b0;
        forever #(period_ns / 2) i_clock = ~i_clock;
    end

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            report_failure($sformatf("mismatch in %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    // Fibonacci taps 16 14 13 11 with one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            r          = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_load(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic auipc);
        return {imm, rd, auipc ? 7'b0010111 : 7'b0110111};
    endfunction

    // RV32I integer rule with shift amount from b[4:0]
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // Reference step on the little-endian mirror
    task automatic model_step(input logic [31:0] inst, input logic kill, output logic valid,
                              output logic [31:0] res);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [7:0]  ad;
        logic        wr;
        a     = regs[inst[19:15]];
        b     = regs[inst[24:20]];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        wr    = 1'b1;
        res   = '0;
        case (inst[6:0])
            7'b0110011: res = alu_ref(inst[14:12], inst[30], a, b);
            7'b0010011: res = alu_ref(inst[14:12], inst[30] && inst[14:12] == 3'd5, a, imm_i);
            7'b0110111: res = {inst[31:12], 12'h000};
            7'b0010111: res = next_pc + {inst[31:12], 12'h000};
            7'b0000011: begin
                ad = 8'(a + imm_i);
                case (inst[14:12])
                    3'd0:    res = {{24{mem[ad][7]}}, mem[ad]};
                    3'd4:    res = {24'h0, mem[ad]};
                    3'd1:    res = {{16{mem[ad + 8'd1][7]}}, mem[ad + 8'd1], mem[ad]};
                    3'd5:    res = {16'h0, mem[ad + 8'd1], mem[ad]};
                    default: res = {mem[ad + 8'd3], mem[ad + 8'd2], mem[ad + 8'd1], mem[ad]};
                endcase
            end
            7'b0100011: begin
                wr = 1'b0;
                ad = 8'(a + {{20{inst[31]}}, inst[31:25], inst[11:7]});
                for (int k = 0; k < 4; k++) begin
                    if (!kill && k < (1 << inst[13:12])) mem[ad + 8'(k)] = b[8*k +: 8];
                end
            end
            default: wr = 1'b0;
        endcase
        valid = wr && !kill && (inst[11:7] != 5'd0);
        if (valid) regs[inst[11:7]] = res;
    endtask

    task automatic check_pending();
        check_value({pend_name, " valid"}, 32'(pend_valid), 32'(o_wb_valid));
        if (pend_valid) begin
            check_value({pend_name, " addr"}, 32'(pend_addr), 32'(o_wb_addr));
            check_value({pend_name, " data"}, pend_data, o_wb_data);
        end
    endtask

    // Issues one instruction and checks the previous result
    task automatic issue(input string name, input logic [31:0] inst, input logic kill = 1'b0);
        @(negedge i_clock);
        check_pending();
        i_inst_valid = 1'b1;
        i_inst       = inst;
        i_pc         = next_pc;
        i_flush      = kill;
        model_step(inst, kill, pend_valid, pend_data);
        pend_addr    = inst[11:7];
        pend_name    = name;
        next_pc      = next_pc + 32'd4;
    endtask

    task automatic bubble();
        @(negedge i_clock);
        check_pending();
        i_inst_valid = 1'b0;
        i_flush      = 1'b0;
        i_inst       = enc_i(12'(rand_bits(12)), 5'd0, 3'd0, 5'(1 + rand_bits(4)));  // Would write rd if valid
        pend_valid   = 1'b0;
        pend_name    = "bubble";
    endtask

    task automatic test_reset();
        repeat (4) bubble();
        for (int r = 0; r < 32; r++) issue("reset read", enc_i(12'h000, 5'(r), 3'd0, 5'(r)));
    endtask

    task automatic test_alu();
        for (int r = 1; r <= 8; r++) begin
            issue("lui setup", enc_u(20'(rand_bits(20)), 5'(r), 1'b0));
            issue("addi setup", enc_i(12'(rand_bits(12)), 5'(r), 3'd0, 5'(r)));
        end
        for (int f3 = 0; f3 < 8; f3++) begin
            for (int alt = 0; alt < 2; alt++) begin
                if (alt == 1 && f3 != 0 && f3 != 5) continue;
                repeat (4) issue($sformatf("r-type f3=%0d alt=%0d", f3, alt),
                                 enc_r(alt ? 7'h20 : 7'h00, 5'(1 + rand_bits(3)),
                                       5'(1 + rand_bits(3)), 3'(f3), 5'(9 + rand_bits(3))));
                if (alt == 1 && f3 != 5) continue;
                repeat (4) issue($sformatf("i-type f3=%0d alt=%0d", f3, alt),
                                 enc_i((f3 == 1 || f3 == 5) ? {alt ? 7'h20 : 7'h00,
                                       5'(rand_bits(5))} : 12'(rand_bits(12)),
                                       5'(1 + rand_bits(3)), 3'(f3), 5'(9 + rand_bits(3))));
            end
        end
        repeat (4) begin
            issue("lui", enc_u(20'(rand_bits(20)), 5'(9 + rand_bits(3)), 1'b0));
            next_pc = rand_bits(30) << 2;       // AUIPC sees a fresh PC
            issue("auipc", enc_u(20'(rand_bits(20)), 5'(9 + rand_bits(3)), 1'b1));
        end
    endtask

    task automatic test_chain();
        issue("chain seed", enc_i(12'(rand_bits(12)), 5'd0, 3'd0, 5'd10));
        repeat (6) begin
            issue("chain add", enc_r(7'h00, 5'd1, 5'd10, 3'd0, 5'd11));
            issue("chain xor", enc_r(7'h00, 5'd2, 5'd11, 3'd4, 5'd10));
            issue("chain sra", enc_r(7'h20, 5'd3, 5'd10, 3'd5, 5'd12));
            issue("chain addi", enc_i(12'(rand_bits(12)), 5'd12, 3'd0, 5'd10));
        end
    endtask

    task automatic test_mem();
        logic [11:0] off;
        repeat (4) begin
            issue("base", enc_i({4'h0, 6'(rand_bits(6)), 2'b00}, 5'd0, 3'd0, 5'd20));
            issue("sw", enc_s(12'h000, 5'd5, 5'd20, 3'd2));
            issue("lw after sw", enc_load(12'h000, 5'd20, 3'd2, 5'd21));
            off = 12'(rand_bits(2));
            issue("sb", enc_s(off, 5'd2, 5'd20, 3'd0));
            issue("lb", enc_load(off, 5'd20, 3'd0, 5'd22));
            issue("lbu", enc_load(off ^ 12'd1, 5'd20, 3'd4, 5'd23));
            off = 12'(rand_bits(1) << 1);
            issue("sh", enc_s(off, 5'd3, 5'd20, 3'd1));
            issue("lh", enc_load(off, 5'd20, 3'd1, 5'd24));
            issue("lhu", enc_load(off ^ 12'd2, 5'd20, 3'd5, 5'd25));
            issue("lw wrap", enc_load(12'h100, 5'd20, 3'd2, 5'd26));  // Base plus 256 bytes
        end
    endtask

    task automatic test_flush();
        issue("flushed addi", enc_i(12'd77, 5'd0, 3'd0, 5'd25), 1'b1);
        issue("read after flush", enc_i(12'h000, 5'd25, 3'd0, 5'd26));
        issue("sw before flush", enc_s(12'h000, 5'd6, 5'd20, 3'd2));
        issue("flushed sw", enc_s(12'h000, 5'd5, 5'd20, 3'd2), 1'b1);
        issue("flushed lw", enc_load(12'h000, 5'd20, 3'd2, 5'd27), 1'b1);
        issue("lw after flushed sw", enc_load(12'h000, 5'd20, 3'd2, 5'd27));
        bubble();
        issue("write x0", enc_i(12'd123, 5'd1, 3'd0, 5'd0));
        issue("read x0", enc_i(12'h000, 5'd0, 3'd0, 5'd28));
    endtask

    initial begin
        #(timeout_ns);
        report_failure("watchdog timeout, the tests did not finish in time");
    end

    initial begin
        for (int k = 0; k < 32; k++) regs[k] = '0;
        for (int k = 0; k < 256; k++) mem[k] = '0;
        i_rst_n      = 1'b0;
        i_inst_valid = 1'b0;
        i_inst       = '0;
        i_pc         = '0;
        i_flush      = 1'b0;
        pend_valid   = 1'b0;
        pend_addr    = '0;
        pend_data    = '0;
        pend_name    = "reset";
        repeat (rst_cycles) @(posedge i_clock);
        @(negedge i_clock);
        i_rst_n = 1'b1;
        test_reset();
        test_alu();
        test_chain();
        test_mem();
        test_flush();
        bubble();                               // Checks the last result
        bubble();
        $display("Done: no errors");
        $finish;
    end

endmodule

// File: verilog/rv_backend_top.sv
`timescale 1ns/1ps

module rv_backend_top (
    input  logic        i_clock,
    input  logic        i_rst_n,
    input  logic        i_inst_valid,
    input  logic [31:0] i_inst,
    input  logic [31:0] i_pc,
    input  logic        i_flush,              // Squashes this cycle's instruction
    output logic        o_wb_valid,
    output logic [4:0]  o_wb_addr,
    output logic [31:0] o_wb_data
);
    import rv_pipe_pkg::*;

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    data_t     rs1_data;
    data_t     rs2_data;

    id_ex_if id_bus ();                       // Decode to register
    id_ex_if ex_bus ();                       // Register to execute

    rv_decode u_decode (
        .i_inst_valid (i_inst_valid),
        .i_inst       (i_inst),
        .i_pc         (i_pc),
        .o_rs1_addr   (rs1_addr),
        .o_rs2_addr   (rs2_addr),
        .i_rs1_data   (rs1_data),
        .i_rs2_data   (rs2_data),
        .o_id         (id_bus.producer)
    );

    rv_regfile u_regfile (
        .i_clock     (i_clock),
        .i_rst_n     (i_rst_n),
        .i_rd_addr_a (rs1_addr),
        .i_rd_addr_b (rs2_addr),
        .o_rd_data_a (rs1_data),
        .o_rd_data_b (rs2_data),
        .i_wr_en     (o_wb_valid),            // Writeback doubles as write port
        .i_wr_addr   (o_wb_addr),
        .i_wr_data   (o_wb_data)
    );

    rv_id_ex_reg u_id_ex (
        .i_clock (i_clock),
        .i_rst_n (i_rst_n),
        .i_flush (i_flush),
        .i_id    (id_bus.register_in),
        .o_ex    (ex_bus.register_out)
    );

    rv_execute u_execute (
        .i_clock   (i_clock),
        .i_rst_n   (i_rst_n),
        .i_ex      (ex_bus.consumer),
        .o_wr_en   (o_wb_valid),
        .o_wr_addr (o_wb_addr),
        .o_wr_data (o_wb_data)
    );

endmodule

// File: verilog/rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
    input  logic                   i_clock,
    input  logic                   i_rst_n,
    id_ex_if.consumer              i_ex,
    output logic                   o_wr_en,      // Register file write port
    output rv_pipe_pkg::reg_addr_t o_wr_addr,
    output rv_pipe_pkg::data_t     o_wr_data
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    data_t                         op_a;
    data_t                         op_b;
    data_t                         alu_res;     // Also the memory address
    data_t                         load_res;
    data_t                         mem_word;
    logic [4:0]                    shamt;
    logic [$clog2(dmem_words)-1:0] word_idx;
    logic [1:0]                    byte_off;
    logic [7:0]                    ld_byte;
    logic [15:0]                   ld_half;
    data_t                         dmem [dmem_words];

    always_comb begin
        case (i_ex.opa_sel)
            OPA_PC:   op_a = i_ex.pc;
            OPA_ZERO: op_a = '0;
            default:  op_a = i_ex.data_a;
        endcase
    end

    assign op_b  = (i_ex.opb_sel == OPB_IMM) ? i_ex.imm : i_ex.data_b;
    assign shamt = op_b[4:0];                 // Low 5 bits only

    always_comb begin
        case (i_ex.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_SLL:    alu_res = op_a << shamt;
            ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_res = {31'b0, op_a < op_b};
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SRL:    alu_res = op_a >> shamt;
            ALU_SRA:    alu_res = data_t'($signed(op_a) >>> shamt);
            ALU_OR:     alu_res = op_a | op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    assign word_idx = alu_res[7:2];           // Wraps at 256 bytes
    assign byte_off = alu_res[1:0];
    assign mem_word = dmem[word_idx];
    assign ld_byte  = mem_word[{byte_off, 3'b000} +: 8];
    assign ld_half  = mem_word[{byte_off[1], 4'b0000} +: 16];

    always_comb begin
        load_res = '0;                        // No read without a load
        if (i_ex.is_load) begin
            case (i_ex.mem_access)
                ACC_BYTE: load_res = {{24{ld_byte[7] & ~i_ex.mem_unsigned}}, ld_byte};
                ACC_HALF: load_res = {{16{ld_half[15] & ~i_ex.mem_unsigned}}, ld_half};
                default:  load_res = mem_word;
            endcase
        end
    end

    // Byte and halfword stores touch only their lanes
    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < dmem_words; i++) begin
                dmem[i] <= '0;
            end
        end else if (i_ex.mem_wr_en) begin
            case (i_ex.mem_access)
                ACC_BYTE: dmem[word_idx][{byte_off, 3'b000} +: 8] <= i_ex.data_b[7:0];
                ACC_HALF: dmem[word_idx][{byte_off[1], 4'b0000} +: 16] <= i_ex.data_b[15:0];
                default:  dmem[word_idx] <= i_ex.data_b;
            endcase
        end
    end

    assign o_wr_en   = i_ex.reg_wr_en;
    assign o_wr_addr = i_ex.rd;
    assign o_wr_data = (i_ex.wb_sel == WB_MEM) ? load_res : alu_res;

endmodule

// File: verilog/rv_id_ex_reg.sv
`timescale 1ns/1ps

module rv_id_ex_reg (
    input  logic          i_clock,
    input  logic          i_rst_n,
    input  logic          i_flush,            // Kills side effects of stage ID
    id_ex_if.register_in  i_id,
    id_ex_if.register_out o_ex
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    // Control fields
    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ex.reg_wr_en    <= 1'b0;
            o_ex.mem_wr_en    <= 1'b0;
            o_ex.is_load      <= 1'b0;
            o_ex.wb_sel       <= WB_ALU;
            o_ex.mem_access   <= ACC_WORD;
            o_ex.mem_unsigned <= 1'b0;
            o_ex.opa_sel      <= OPA_REG;
            o_ex.opb_sel      <= OPB_REG;
            o_ex.alu_op       <= ALU_UNKNOWN;
        end else begin
            o_ex.reg_wr_en    <= i_id.reg_wr_en && !i_flush;  // Squash
            o_ex.mem_wr_en    <= i_id.mem_wr_en && !i_flush;  // Squash
            o_ex.is_load      <= i_id.is_load && !i_flush;    // Squash
            o_ex.wb_sel       <= i_id.wb_sel;
            o_ex.mem_access   <= i_id.mem_access;
            o_ex.mem_unsigned <= i_id.mem_unsigned;
            o_ex.opa_sel      <= i_id.opa_sel;
            o_ex.opb_sel      <= i_id.opb_sel;
            o_ex.alu_op       <= i_id.alu_op;
        end
    end

    // Payload, meaningless while the enables are low
    always_ff @(posedge i_clock) begin
        o_ex.pc     <= i_id.pc;
        o_ex.imm    <= i_id.imm;
        o_ex.data_a <= i_id.data_a;
        o_ex.data_b <= i_id.data_b;
        o_ex.rd     <= i_id.rd;
    end

endmodule

// File: verilog/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
    input  logic                   i_inst_valid,
    input  rv_isa_pkg::inst_t      i_inst,
    input  rv_pipe_pkg::data_t     i_pc,
    output rv_pipe_pkg::reg_addr_t o_rs1_addr,   // To register file
    output rv_pipe_pkg::reg_addr_t o_rs2_addr,
    input  rv_pipe_pkg::data_t     i_rs1_data,
    input  rv_pipe_pkg::data_t     i_rs2_data,
    id_ex_if.producer              o_id
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    data_t imm_i;
    data_t imm_s;
    data_t imm_u;
    logic  known;                             // Supported opcode
    logic  wr_reg;                            // Opcode writes rd
    logic  wr_mem;                            // Opcode is a store
    logic  load;

    // funct7[5] picks SUB and SRA, SUB only for the register form
    function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt,
                                               input logic reg_form);
        case (f3)
            3'b000:  return (alt && reg_form) ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign imm_i = {{20{i_inst.i.imm[11]}}, i_inst.i.imm};
    assign imm_s = {{20{i_inst.s.imm_hi[6]}}, i_inst.s.imm_hi, i_inst.s.imm_lo};
    assign imm_u = {i_inst.u.imm, 12'h000};

    assign o_rs1_addr  = i_inst.r.rs1;
    assign o_rs2_addr  = i_inst.r.rs2;
    assign o_id.pc     = i_pc;
    assign o_id.data_a = i_rs1_data;
    assign o_id.data_b = i_rs2_data;
    assign o_id.rd     = i_inst.r.rd;

    always_comb begin
        known             = 1'b1;
        wr_reg            = 1'b1;
        wr_mem            = 1'b0;
        load              = 1'b0;
        o_id.imm          = imm_i;
        o_id.alu_op       = ALU_ADD;
        o_id.opa_sel      = OPA_REG;
        o_id.opb_sel      = OPB_IMM;
        o_id.wb_sel       = WB_ALU;
        o_id.mem_access   = ACC_WORD;
        o_id.mem_unsigned = 1'b0;
        case (i_inst.r.opcode)
            OPC_OP: begin
                o_id.alu_op  = alu_from_funct(i_inst.r.funct3, i_inst.r.funct7[5], 1'b1);
                o_id.opb_sel = OPB_REG;
            end
            OPC_OP_IMM: begin
                o_id.alu_op = alu_from_funct(i_inst.i.funct3, i_inst.r.funct7[5], 1'b0);
            end
            OPC_LUI: begin
                o_id.imm    = imm_u;
                o_id.alu_op = ALU_PASS_B;
            end
            OPC_AUIPC: begin
                o_id.imm     = imm_u;
                o_id.opa_sel = OPA_PC;        // pc + imm
            end
            OPC_LOAD: begin
                load              = 1'b1;
                o_id.wb_sel       = WB_MEM;
                o_id.mem_access   = data_access_e'(i_inst.i.funct3[1:0]);
                o_id.mem_unsigned = i_inst.i.funct3[2];
            end
            OPC_STORE: begin
                wr_reg          = 1'b0;
                wr_mem          = 1'b1;
                o_id.imm        = imm_s;
                o_id.mem_access = data_access_e'(i_inst.s.funct3[1:0]);
            end
            default: begin
                known       = 1'b0;           // Turns into a bubble
                o_id.alu_op = ALU_UNKNOWN;
            end
        endcase
    end

    assign o_id.reg_wr_en = i_inst_valid && known && wr_reg && (i_inst.r.rd != '0);
    assign o_id.mem_wr_en = i_inst_valid && known && wr_mem;
    assign o_id.is_load   = i_inst_valid && known && load;

endmodule

// File: verilog/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
    input  logic                   i_clock,
    input  logic                   i_rst_n,
    input  rv_pipe_pkg::reg_addr_t i_rd_addr_a,  // Decode rs1
    input  rv_pipe_pkg::reg_addr_t i_rd_addr_b,  // Decode rs2
    output rv_pipe_pkg::data_t     o_rd_data_a,
    output rv_pipe_pkg::data_t     o_rd_data_b,
    input  logic                   i_wr_en,      // From execute
    input  rv_pipe_pkg::reg_addr_t i_wr_addr,
    input  rv_pipe_pkg::data_t     i_wr_data
);
    import rv_pipe_pkg::*;

    data_t regs [1:31];                       // x0 not stored

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && (i_wr_addr != '0)) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // Write data wins over stored value, covers the instruction ahead
    function automatic data_t read_port(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;                        // x0 hardwired
        end else if (i_wr_en && (addr == i_wr_addr)) begin
            return i_wr_data;                 // Bypass
        end
        return regs[addr];
    endfunction

    assign o_rd_data_a = read_port(i_rd_addr_a);
    assign o_rd_data_b = read_port(i_rd_addr_b);

endmodule

// File: verilog/id_ex_if.sv
`timescale 1ns/1ps

interface id_ex_if;
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    data_t        pc;
    data_t        imm;                        // Selected immediate
    data_t        data_a;                     // rs1 value
    data_t        data_b;                     // rs2 value, also store data
    reg_addr_t    rd;
    logic         reg_wr_en;
    wb_sel_e      wb_sel;
    logic         mem_wr_en;
    data_access_e mem_access;
    logic         mem_unsigned;               // LBU, LHU
    logic         is_load;
    opa_sel_e     opa_sel;
    opb_sel_e     opb_sel;
    alu_op_e      alu_op;

    modport producer (output pc, imm, data_a, data_b, rd, reg_wr_en, wb_sel, mem_wr_en,
                      mem_access, mem_unsigned, is_load, opa_sel, opb_sel, alu_op);

    modport register_in (input pc, imm, data_a, data_b, rd, reg_wr_en, wb_sel, mem_wr_en,
                         mem_access, mem_unsigned, is_load, opa_sel, opb_sel, alu_op);

    modport register_out (output pc, imm, data_a, data_b, rd, reg_wr_en, wb_sel, mem_wr_en,
                          mem_access, mem_unsigned, is_load, opa_sel, opb_sel, alu_op);

    modport consumer (input pc, imm, data_a, data_b, rd, reg_wr_en, wb_sel, mem_wr_en,
                      mem_access, mem_unsigned, is_load, opa_sel, opb_sel, alu_op);

endinterface

// File: verilog/rv_pipe_pkg.sv
package rv_pipe_pkg;

    localparam int xlen       = 32;
    localparam int dmem_words = 64;           // 256 bytes, wraps

    typedef logic [xlen-1:0] data_t;
    typedef logic [4:0]      reg_addr_t;

    typedef enum logic [1:0] {
        OPA_REG,                              // rs1 value
        OPA_PC,                               // AUIPC
        OPA_ZERO
    } opa_sel_e;

    typedef enum logic [1:0] {
        OPB_REG,                              // rs2 value
        OPB_IMM
    } opb_sel_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM                                // Load result
    } wb_sel_e;

endpackage

// File: verilog/rv_isa_pkg.sv
package rv_isa_pkg;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,              // Register-register ALU
        OPC_OP_IMM = 7'b0010011,              // Register-immediate ALU
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B,                           // Operand B straight through
        ALU_UNKNOWN                           // Reset value
    } alu_op_e;

    // Encoding matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        ACC_BYTE = 2'b00,
        ACC_HALF = 2'b01,
        ACC_WORD = 2'b10                      // Reset value
    } data_access_e;

    typedef struct packed {
        logic [6:0]  funct7;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0] imm;                     // Sign bit at 11
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } inst_i_t;

    typedef struct packed {
        logic [6:0]  imm_hi;                  // imm[11:5]
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  imm_lo;                  // imm[4:0]
        opcode_e     opcode;
    } inst_s_t;

    typedef struct packed {
        logic [19:0] imm;                     // Upper 20 bits
        logic [4:0]  rd;
        opcode_e     opcode;
    } inst_u_t;

    // Same 32-bit word seen through each format
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
        inst_s_t s;
        inst_u_t u;
    } inst_t;

endpackage
